// ==== logic/rackctl_pkg.sv ====
package rackctl_pkg;

    // ####################################################################
    // Link geometry.
    // ####################################################################

    localparam int LINK_COUNT = 7;
    localparam int ADDR_W     = 22;
    localparam int DATA_W     = 32;
    localparam int STATUS_W   = 2;

    typedef logic [ADDR_W-1:0]   link_addr_t;
    typedef logic [DATA_W-1:0]   link_data_t;
    typedef logic [STATUS_W-1:0] link_status_t;

    // Reply status codes.
    localparam link_status_t STATUS_ACK = 2'd0;
    localparam link_status_t STATUS_ERR = 2'd1;
    localparam link_status_t STATUS_RTY = 2'd2;

    // ####################################################################
    // Frame lengths.
    // ####################################################################

    // Request is start, we, address, data.
    localparam int REQ_BITS = 1 + 1 + ADDR_W + DATA_W;

    // Reply is start, status, data.
    localparam int RSP_BITS = 1 + STATUS_W + DATA_W;

    // ####################################################################
    // State machines.
    // ####################################################################

    typedef enum logic [1:0] {
        PHY_IDLE,
        PHY_SEND,
        PHY_WAIT,
        PHY_RECV
    } phy_state_t;

    typedef enum logic [1:0] {
        BR_IDLE,
        BR_BUSY,
        BR_DONE
    } bridge_state_t;

endpackage

// ==== logic/rackctl_phy.sv ====
`timescale 1ns/1ps

module rackctl_phy #(
    parameter bit INV            = 1'b0,
    parameter int TIMEOUT_CYCLES = 1000
) (
    input  logic                      wb_clk_i,
    input  logic                      rst_n_i,
    input  logic                      req_valid_i,
    output logic                      req_ready_o,
    input  logic                      req_we_i,
    input  rackctl_pkg::link_addr_t   req_adr_i,
    input  rackctl_pkg::link_data_t   req_dat_i,
    output logic                      rsp_valid_o,
    output rackctl_pkg::link_status_t rsp_status_o,
    output rackctl_pkg::link_data_t   rsp_dat_o,
    output logic                      rsp_timeout_o,
    output logic                      link_o,
    input  logic                      link_i
);

    localparam int REQ_BITS = rackctl_pkg::REQ_BITS;
    localparam int RSP_BITS = rackctl_pkg::RSP_BITS;
    localparam int CNT_W    = $clog2(REQ_BITS);
    localparam int TMO_W    = $clog2(TIMEOUT_CYCLES + 1);

    rackctl_pkg::phy_state_t state_q;

    logic [REQ_BITS-1:0] tx_shift_q;
    logic [RSP_BITS-2:0] rx_shift_q;
    logic [CNT_W-1:0]    bit_cnt_q;
    logic [TMO_W-1:0]    idle_cnt_q;
    logic                rsp_valid_q;
    logic                rsp_timeout_q;
    logic                rx_bit;
    logic                tx_bit;

    // Undo the board polarity in both directions.
    assign rx_bit = link_i ^ INV;
    assign tx_bit = (state_q == rackctl_pkg::PHY_SEND) ? tx_shift_q[REQ_BITS-1] : 1'b0;
    assign link_o = tx_bit ^ INV;

    assign req_ready_o   = (state_q == rackctl_pkg::PHY_IDLE);
    assign rsp_valid_o   = rsp_valid_q;
    assign rsp_timeout_o = rsp_timeout_q;
    assign rsp_status_o  = rx_shift_q[rackctl_pkg::DATA_W +: rackctl_pkg::STATUS_W];
    assign rsp_dat_o     = rx_shift_q[rackctl_pkg::DATA_W-1:0];

    // ####################################################################
    // Frame sequencing.
    // ####################################################################

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q       <= rackctl_pkg::PHY_IDLE;
            bit_cnt_q     <= '0;
            idle_cnt_q    <= '0;
            rsp_valid_q   <= 1'b0;
            rsp_timeout_q <= 1'b0;
        end else begin
            rsp_valid_q   <= 1'b0;
            rsp_timeout_q <= 1'b0;
            case (state_q)
                rackctl_pkg::PHY_IDLE: begin
                    if (req_valid_i) begin
                        state_q   <= rackctl_pkg::PHY_SEND;
                        bit_cnt_q <= CNT_W'(REQ_BITS - 1);
                    end
                end
                rackctl_pkg::PHY_SEND: begin
                    if (bit_cnt_q == '0) begin
                        state_q    <= rackctl_pkg::PHY_WAIT;
                        idle_cnt_q <= '0;
                    end else begin
                        bit_cnt_q <= bit_cnt_q - 1'b1;
                    end
                end
                rackctl_pkg::PHY_WAIT: begin
                    // A high bit here is the reply start bit.
                    if (rx_bit) begin
                        state_q   <= rackctl_pkg::PHY_RECV;
                        bit_cnt_q <= CNT_W'(RSP_BITS - 2);
                    end else if (idle_cnt_q == TMO_W'(TIMEOUT_CYCLES - 1)) begin
                        state_q       <= rackctl_pkg::PHY_IDLE;
                        rsp_timeout_q <= 1'b1;
                    end else begin
                        idle_cnt_q <= idle_cnt_q + 1'b1;
                    end
                end
                rackctl_pkg::PHY_RECV: begin
                    if (bit_cnt_q == '0) begin
                        state_q     <= rackctl_pkg::PHY_IDLE;
                        rsp_valid_q <= 1'b1;
                    end else begin
                        bit_cnt_q <= bit_cnt_q - 1'b1;
                    end
                end
                default: state_q <= rackctl_pkg::PHY_IDLE;
            endcase
        end
    end

    // Shift registers, MSB first on the wire.
    always_ff @(posedge wb_clk_i) begin
        if (state_q == rackctl_pkg::PHY_IDLE && req_valid_i) begin
            tx_shift_q <= {1'b1, req_we_i, req_adr_i, req_dat_i};
        end else if (state_q == rackctl_pkg::PHY_SEND) begin
            tx_shift_q <= {tx_shift_q[REQ_BITS-2:0], 1'b0};
        end
        if (state_q == rackctl_pkg::PHY_RECV) begin
            rx_shift_q <= {rx_shift_q[RSP_BITS-3:0], rx_bit};
        end
    end

endmodule

// ==== logic/rackctl_wb_bridge.sv ====
`timescale 1ns/1ps

module rackctl_wb_bridge #(
    parameter bit INV            = 1'b0,
    parameter int TIMEOUT_CYCLES = 1000
) (
    input  logic                    wb_clk_i,
    input  logic                    rst_n_i,
    input  logic                    gtp_cyc_i,
    input  logic                    gtp_stb_i,
    input  logic                    gtp_we_i,
    input  rackctl_pkg::link_addr_t gtp_adr_i,
    input  rackctl_pkg::link_data_t gtp_dat_i,
    output rackctl_pkg::link_data_t gtp_dat_o,
    output logic                    gtp_ack_o,
    output logic                    gtp_err_o,
    output logic                    gtp_rty_o,
    input  logic                    dbg_cyc_i,
    input  logic                    dbg_stb_i,
    input  logic                    dbg_we_i,
    input  rackctl_pkg::link_addr_t dbg_adr_i,
    input  rackctl_pkg::link_data_t dbg_dat_i,
    output rackctl_pkg::link_data_t dbg_dat_o,
    output logic                    dbg_ack_o,
    output logic                    dbg_err_o,
    output logic                    dbg_rty_o,
    output logic                    bridge_err_o,
    input  logic                    err_rst_i,
    output logic                    link_o,
    input  logic                    link_i
);

    rackctl_pkg::bridge_state_t state_q;

    logic                      gtp_req;
    logic                      dbg_req;
    logic                      gnt_gtp_q;
    logic                      req_valid_q;
    logic                      req_ready;
    logic                      req_we_q;
    rackctl_pkg::link_addr_t   req_adr_q;
    rackctl_pkg::link_data_t   req_dat_q;
    logic                      rsp_valid;
    logic                      rsp_timeout;
    rackctl_pkg::link_status_t rsp_status;
    rackctl_pkg::link_data_t   rsp_dat;
    rackctl_pkg::link_data_t   dat_q;
    logic                      ack_q;
    logic                      err_q;
    logic                      rty_q;
    logic                      bridge_err_q;

    assign gtp_req = gtp_cyc_i && gtp_stb_i;
    assign dbg_req = dbg_cyc_i && dbg_stb_i;

    // ####################################################################
    // Arbitration and request launch.
    // ####################################################################

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q     <= rackctl_pkg::BR_IDLE;
            gnt_gtp_q   <= 1'b0;
            req_valid_q <= 1'b0;
            ack_q       <= 1'b0;
            err_q       <= 1'b0;
            rty_q       <= 1'b0;
        end else begin
            ack_q <= 1'b0;
            err_q <= 1'b0;
            rty_q <= 1'b0;
            case (state_q)
                rackctl_pkg::BR_IDLE: begin
                    // gtp wins a tie.
                    if (gtp_req || dbg_req) begin
                        gnt_gtp_q   <= gtp_req;
                        req_valid_q <= 1'b1;
                        state_q     <= rackctl_pkg::BR_BUSY;
                    end
                end
                rackctl_pkg::BR_BUSY: begin
                    if (req_valid_q && req_ready) begin
                        req_valid_q <= 1'b0;
                    end
                    if (rsp_timeout) begin
                        err_q   <= 1'b1;
                        state_q <= rackctl_pkg::BR_DONE;
                    end else if (rsp_valid) begin
                        state_q <= rackctl_pkg::BR_DONE;
                        case (rsp_status)
                            rackctl_pkg::STATUS_ACK: ack_q <= 1'b1;
                            rackctl_pkg::STATUS_RTY: rty_q <= 1'b1;
                            default:                 err_q <= 1'b1;
                        endcase
                    end
                end
                rackctl_pkg::BR_DONE: begin
                    state_q <= rackctl_pkg::BR_IDLE;
                end
                default: state_q <= rackctl_pkg::BR_IDLE;
            endcase
        end
    end

    // Request fields; data goes out as zero on a read.
    always_ff @(posedge wb_clk_i) begin
        if (state_q == rackctl_pkg::BR_IDLE) begin
            if (gtp_req) begin
                req_we_q  <= gtp_we_i;
                req_adr_q <= gtp_adr_i;
                req_dat_q <= gtp_we_i ? gtp_dat_i : '0;
            end else begin
                req_we_q  <= dbg_we_i;
                req_adr_q <= dbg_adr_i;
                req_dat_q <= dbg_we_i ? dbg_dat_i : '0;
            end
        end
        if (rsp_valid) begin
            dat_q <= rsp_dat;
        end
    end

    // Sticky link error.
    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            bridge_err_q <= 1'b0;
        end else if (err_rst_i) begin
            bridge_err_q <= 1'b0;
        end else if (rsp_timeout) begin
            bridge_err_q <= 1'b1;
        end
    end

    assign bridge_err_o = bridge_err_q;

    // Replies go to the granted master only.
    assign gtp_ack_o = ack_q && gnt_gtp_q;
    assign gtp_err_o = err_q && gnt_gtp_q;
    assign gtp_rty_o = rty_q && gnt_gtp_q;
    assign gtp_dat_o = gnt_gtp_q ? dat_q : '0;
    assign dbg_ack_o = ack_q && !gnt_gtp_q;
    assign dbg_err_o = err_q && !gnt_gtp_q;
    assign dbg_rty_o = rty_q && !gnt_gtp_q;
    assign dbg_dat_o = gnt_gtp_q ? '0 : dat_q;

    rackctl_phy #(
        .INV            (INV),
        .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
    ) u_phy (
        .wb_clk_i      (wb_clk_i),
        .rst_n_i       (rst_n_i),
        .req_valid_i   (req_valid_q),
        .req_ready_o   (req_ready),
        .req_we_i      (req_we_q),
        .req_adr_i     (req_adr_q),
        .req_dat_i     (req_dat_q),
        .rsp_valid_o   (rsp_valid),
        .rsp_status_o  (rsp_status),
        .rsp_dat_o     (rsp_dat),
        .rsp_timeout_o (rsp_timeout),
        .link_o        (link_o),
        .link_i        (link_i)
    );

endmodule

// ==== logic/surf_bridge.sv ====
`timescale 1ns/1ps

module surf_bridge #(
    parameter int                   NUM_LINKS      = rackctl_pkg::LINK_COUNT,
    parameter logic [NUM_LINKS-1:0] LINK_INV       = '0,
    parameter int                   TIMEOUT_CYCLES = 1000
) (
    input  logic                    wb_clk_i,
    input  logic                    rst_n_i,
    input  logic                    gtp_cyc_i,
    input  logic                    gtp_stb_i,
    input  logic                    gtp_we_i,
    input  logic [24:0]             gtp_adr_i,
    input  logic [3:0]              gtp_sel_i,
    input  rackctl_pkg::link_data_t gtp_dat_i,
    output rackctl_pkg::link_data_t gtp_dat_o,
    output logic                    gtp_ack_o,
    output logic                    gtp_err_o,
    output logic                    gtp_rty_o,
    input  logic [2:0]              gtp_select_i,
    input  logic                    dbg_cyc_i,
    input  logic                    dbg_stb_i,
    input  logic                    dbg_we_i,
    input  logic [24:0]             dbg_adr_i,
    input  logic [3:0]              dbg_sel_i,
    input  rackctl_pkg::link_data_t dbg_dat_i,
    output rackctl_pkg::link_data_t dbg_dat_o,
    output logic                    dbg_ack_o,
    output logic                    dbg_err_o,
    output logic                    dbg_rty_o,
    input  logic [2:0]              dbg_select_i,
    output logic [NUM_LINKS-1:0]    bridge_err_o,
    input  logic                    err_rst_i,
    output logic [NUM_LINKS-1:0]    link_o,
    input  logic [NUM_LINKS-1:0]    link_i
);

    // Index 0 is gtp, index 1 is dbg.
    localparam int MASTERS = 2;

    logic                    m_cyc    [MASTERS];
    logic                    m_stb    [MASTERS];
    logic                    m_we     [MASTERS];
    logic [2:0]              m_select [MASTERS];
    rackctl_pkg::link_addr_t m_adr    [MASTERS];
    rackctl_pkg::link_data_t m_wdat   [MASTERS];
    rackctl_pkg::link_data_t m_rdat   [MASTERS];
    logic                    m_ack    [MASTERS];
    logic                    m_err    [MASTERS];
    logic                    m_rty    [MASTERS];
    logic [MASTERS-1:0]      m_bad_q;

    logic                    l_cyc [MASTERS][NUM_LINKS];
    logic                    l_ack [MASTERS][NUM_LINKS];
    logic                    l_err [MASTERS][NUM_LINKS];
    logic                    l_rty [MASTERS][NUM_LINKS];
    rackctl_pkg::link_data_t l_dat [MASTERS][NUM_LINKS];

    function automatic logic select_ok(input logic [2:0] sel);
        return (sel != 3'd0) && (int'(sel) <= NUM_LINKS);
    endfunction

    // Unselected byte lanes are written as zero.
    function automatic rackctl_pkg::link_data_t byte_mask(
        input logic [3:0]              sel,
        input rackctl_pkg::link_data_t dat
    );
        rackctl_pkg::link_data_t masked;
        for (int b = 0; b < 4; b++) begin
            masked[8*b +: 8] = sel[b] ? dat[8*b +: 8] : 8'h00;
        end
        return masked;
    endfunction

    assign m_cyc[0]    = gtp_cyc_i;
    assign m_stb[0]    = gtp_stb_i;
    assign m_we[0]     = gtp_we_i;
    assign m_select[0] = gtp_select_i;
    assign m_adr[0]    = gtp_adr_i[rackctl_pkg::ADDR_W-1:0];
    assign m_wdat[0]   = byte_mask(gtp_sel_i, gtp_dat_i);
    assign m_cyc[1]    = dbg_cyc_i;
    assign m_stb[1]    = dbg_stb_i;
    assign m_we[1]     = dbg_we_i;
    assign m_select[1] = dbg_select_i;
    assign m_adr[1]    = dbg_adr_i[rackctl_pkg::ADDR_W-1:0];
    assign m_wdat[1]   = byte_mask(dbg_sel_i, dbg_dat_i);

    // ####################################################################
    // Bad select and reply mux.
    // ####################################################################

    always_ff @(posedge wb_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            m_bad_q <= '0;
        end else begin
            for (int m = 0; m < MASTERS; m++) begin
                m_bad_q[m] <= m_cyc[m] && m_stb[m] && !select_ok(m_select[m]) && !m_bad_q[m];
            end
        end
    end

    always_comb begin
        for (int m = 0; m < MASTERS; m++) begin
            m_ack[m]  = 1'b0;
            m_err[m]  = m_bad_q[m];
            m_rty[m]  = 1'b0;
            m_rdat[m] = '0;
            for (int i = 0; i < NUM_LINKS; i++) begin
                if (int'(m_select[m]) == i + 1) begin
                    m_ack[m]  = l_ack[m][i];
                    m_err[m]  = m_bad_q[m] || l_err[m][i];
                    m_rty[m]  = l_rty[m][i];
                    m_rdat[m] = l_dat[m][i];
                end
            end
        end
    end

    assign gtp_ack_o = m_ack[0];
    assign gtp_err_o = m_err[0];
    assign gtp_rty_o = m_rty[0];
    assign gtp_dat_o = m_rdat[0];
    assign dbg_ack_o = m_ack[1];
    assign dbg_err_o = m_err[1];
    assign dbg_rty_o = m_rty[1];
    assign dbg_dat_o = m_rdat[1];

    // ####################################################################
    // One bridge per link.
    // ####################################################################

    for (genvar i = 0; i < NUM_LINKS; i++) begin : g_link
        assign l_cyc[0][i] = m_cyc[0] && (int'(m_select[0]) == i + 1);
        assign l_cyc[1][i] = m_cyc[1] && (int'(m_select[1]) == i + 1);

        rackctl_wb_bridge #(
            .INV            (LINK_INV[i]),
            .TIMEOUT_CYCLES (TIMEOUT_CYCLES)
        ) u_bridge (
            .wb_clk_i     (wb_clk_i),
            .rst_n_i      (rst_n_i),
            .gtp_cyc_i    (l_cyc[0][i]),
            .gtp_stb_i    (m_stb[0]),
            .gtp_we_i     (m_we[0]),
            .gtp_adr_i    (m_adr[0]),
            .gtp_dat_i    (m_wdat[0]),
            .gtp_dat_o    (l_dat[0][i]),
            .gtp_ack_o    (l_ack[0][i]),
            .gtp_err_o    (l_err[0][i]),
            .gtp_rty_o    (l_rty[0][i]),
            .dbg_cyc_i    (l_cyc[1][i]),
            .dbg_stb_i    (m_stb[1]),
            .dbg_we_i     (m_we[1]),
            .dbg_adr_i    (m_adr[1]),
            .dbg_dat_i    (m_wdat[1]),
            .dbg_dat_o    (l_dat[1][i]),
            .dbg_ack_o    (l_ack[1][i]),
            .dbg_err_o    (l_err[1][i]),
            .dbg_rty_o    (l_rty[1][i]),
            .bridge_err_o (bridge_err_o[i]),
            .err_rst_i    (err_rst_i),
            .link_o       (link_o[i]),
            .link_i       (link_i[i])
        );
    end

endmodule

// ==== verification/rackctl_board_model.sv ====
`timescale 1ns/1ps

module rackctl_board_model #(
    parameter bit INV = 1'b0
) (
    input  logic wb_clk_i,
    input  logic enable_i,
    input  logic link_i,
    output logic link_o
);

    localparam int REQ_BITS   = rackctl_pkg::REQ_BITS;
    localparam int RSP_BITS   = rackctl_pkg::RSP_BITS;
    localparam int TURNAROUND = 3;

    logic [rackctl_pkg::DATA_W-1:0] regs [16];

    logic                             rx_bit;
    logic [REQ_BITS-2:0]              req;
    logic                             req_we;
    logic [rackctl_pkg::ADDR_W-1:0]   req_adr;
    logic [rackctl_pkg::DATA_W-1:0]   req_dat;
    logic [1:0]                       status;
    logic [rackctl_pkg::DATA_W-1:0]   rdat;
    logic [RSP_BITS-1:0]              rsp;

    assign rx_bit = link_i ^ INV;

    initial begin
        for (int i = 0; i < 16; i++) begin
            regs[i] = '0;
        end
        link_o = INV;
        forever begin
            @(posedge wb_clk_i);
            if (rx_bit === 1'b1) begin
                // Start bit seen, collect we, address and data.
                for (int i = REQ_BITS - 2; i >= 0; i--) begin
                    @(posedge wb_clk_i);
                    req[i] = rx_bit;
                end
                {req_we, req_adr, req_dat} = req;
                // A silenced board still swallows the frame.
                if (enable_i) begin
                    rdat = '0;
                    if (req_adr[rackctl_pkg::ADDR_W-1]) begin
                        status = rackctl_pkg::STATUS_RTY;
                    end else if (req_adr[rackctl_pkg::ADDR_W-2]) begin
                        status = rackctl_pkg::STATUS_ERR;
                    end else begin
                        status = rackctl_pkg::STATUS_ACK;
                        if (req_we) begin
                            regs[req_adr[3:0]] = req_dat;
                        end else begin
                            rdat = regs[req_adr[3:0]];
                        end
                    end
                    rsp = {1'b1, status, rdat};
                    repeat (TURNAROUND) @(posedge wb_clk_i);
                    for (int i = RSP_BITS - 1; i >= 0; i--) begin
                        link_o <= rsp[i] ^ INV;
                        @(posedge wb_clk_i);
                    end
                    link_o <= INV;
                end
            end
        end
    end

endmodule

// ==== verification/tb_surf_bridge.sv ====
`timescale 1ns/1ps

module tb_surf_bridge;

    localparam int             NUM_LINKS   = 7;
    localparam logic [6:0]     LINK_INV    = 7'b0000101;
    localparam int             TIMEOUT     = 200;
    localparam int             WAIT_LIMIT  = 500;
    localparam int             MIN_LATENCY = rackctl_pkg::REQ_BITS + rackctl_pkg::RSP_BITS + 4;
    // Replies are packed as {rty, err, ack}.
    localparam logic [2:0]     RSP_ACK     = 3'b001;
    localparam logic [2:0]     RSP_ERR     = 3'b010;
    localparam logic [2:0]     RSP_RTY     = 3'b100;

    logic                           wb_clk;
    logic                           rst_n;
    logic                           gtp_cyc;
    logic                           gtp_stb;
    logic                           gtp_we;
    logic [24:0]                    gtp_adr;
    logic [3:0]                     gtp_sel;
    logic [rackctl_pkg::DATA_W-1:0] gtp_wdat;
    logic [rackctl_pkg::DATA_W-1:0] gtp_rdat;
    logic                           gtp_ack;
    logic                           gtp_err;
    logic                           gtp_rty;
    logic [2:0]                     gtp_select;
    logic                           dbg_cyc;
    logic                           dbg_stb;
    logic                           dbg_we;
    logic [24:0]                    dbg_adr;
    logic [3:0]                     dbg_sel;
    logic [rackctl_pkg::DATA_W-1:0] dbg_wdat;
    logic [rackctl_pkg::DATA_W-1:0] dbg_rdat;
    logic                           dbg_ack;
    logic                           dbg_err;
    logic                           dbg_rty;
    logic [2:0]                     dbg_select;
    logic [NUM_LINKS-1:0]           bridge_err;
    logic                           err_rst;
    logic [NUM_LINKS-1:0]           link_tx;
    logic [NUM_LINKS-1:0]           link_rx;
    logic [NUM_LINKS-1:0]           board_en;

    logic [rackctl_pkg::DATA_W-1:0] rdat_g;
    logic [rackctl_pkg::DATA_W-1:0] rdat_d;
    logic [2:0]                     rsp_g;
    logic [2:0]                     rsp_d;
    time                            done_g;
    time                            done_d;

    surf_bridge #(
        .NUM_LINKS      (NUM_LINKS),
        .LINK_INV       (LINK_INV),
        .TIMEOUT_CYCLES (TIMEOUT)
    ) i_dut (
        .wb_clk_i     (wb_clk),
        .rst_n_i      (rst_n),
        .gtp_cyc_i    (gtp_cyc),
        .gtp_stb_i    (gtp_stb),
        .gtp_we_i     (gtp_we),
        .gtp_adr_i    (gtp_adr),
        .gtp_sel_i    (gtp_sel),
        .gtp_dat_i    (gtp_wdat),
        .gtp_dat_o    (gtp_rdat),
        .gtp_ack_o    (gtp_ack),
        .gtp_err_o    (gtp_err),
        .gtp_rty_o    (gtp_rty),
        .gtp_select_i (gtp_select),
        .dbg_cyc_i    (dbg_cyc),
        .dbg_stb_i    (dbg_stb),
        .dbg_we_i     (dbg_we),
        .dbg_adr_i    (dbg_adr),
        .dbg_sel_i    (dbg_sel),
        .dbg_dat_i    (dbg_wdat),
        .dbg_dat_o    (dbg_rdat),
        .dbg_ack_o    (dbg_ack),
        .dbg_err_o    (dbg_err),
        .dbg_rty_o    (dbg_rty),
        .dbg_select_i (dbg_select),
        .bridge_err_o (bridge_err),
        .err_rst_i    (err_rst),
        .link_o       (link_tx),
        .link_i       (link_rx)
    );

    for (genvar i = 0; i < NUM_LINKS; i++) begin : g_board
        rackctl_board_model #(
            .INV (LINK_INV[i])
        ) i_board (
            .wb_clk_i (wb_clk),
            .enable_i (board_en[i]),
            .link_i   (link_tx[i]),
            .link_o   (link_rx[i])
        );
    end

    initial begin
        wb_clk = 1'b0;
        forever #5 wb_clk = ~wb_clk;
    end

    // ####################################################################
    // Failure reporting and bus tasks.
    // ####################################################################

    task automatic stop_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped after a failure.");
    endtask

    task automatic report_error(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        stop_run();
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        stop_run();
    endtask

    function automatic logic [rackctl_pkg::ADDR_W-1:0] reg_addr(input int link);
        logic [rackctl_pkg::ADDR_W-1:0] a;
        a = '0;
        a[15:4] = 12'h120;
        a[3:0] = link[3:0];
        return a;
    endfunction

    function automatic logic [rackctl_pkg::DATA_W-1:0] reg_data(input int link);
        return 32'hA500_C0DE | (link << 16);
    endfunction

    task automatic drive_master(
        input int                             m,
        input logic                           active,
        input logic [2:0]                     select,
        input logic                           we,
        input logic [rackctl_pkg::ADDR_W-1:0] adr,
        input logic [rackctl_pkg::DATA_W-1:0] dat
    );
        if (m == 0) begin
            gtp_cyc = active;
            gtp_stb = active;
            gtp_we = we;
            gtp_adr = {3'b000, adr};
            gtp_sel = 4'hF;
            gtp_wdat = dat;
            gtp_select = select;
        end else begin
            dbg_cyc = active;
            dbg_stb = active;
            dbg_we = we;
            dbg_adr = {3'b000, adr};
            dbg_sel = 4'hF;
            dbg_wdat = dat;
            dbg_select = select;
        end
    endtask

    task automatic bus_access(
        input  int                             m,
        input  logic [2:0]                     select,
        input  logic                           we,
        input  logic [rackctl_pkg::ADDR_W-1:0] adr,
        input  logic [rackctl_pkg::DATA_W-1:0] wdat,
        output logic [rackctl_pkg::DATA_W-1:0] rdat,
        output logic [2:0]                     rsp
    );
        int   cycles;
        logic [2:0] seen;
        cycles = 0;
        seen = 3'b000;
        @(posedge wb_clk);
        #1;
        drive_master(m, 1'b1, select, we, adr, wdat);
        while (seen == 3'b000) begin
            if (cycles == WAIT_LIMIT) begin
                report_failure($sformatf("Master %0d got no reply within %0d cycles.",
                                         m, WAIT_LIMIT));
            end
            @(posedge wb_clk);
            #1;
            cycles++;
            seen = (m == 0) ? {gtp_rty, gtp_err, gtp_ack} : {dbg_rty, dbg_err, dbg_ack};
            rdat = (m == 0) ? gtp_rdat : dbg_rdat;
        end
        // Hold the cycle through the reply edge, as a Wishbone master does.
        @(posedge wb_clk);
        #1;
        drive_master(m, 1'b0, 3'd0, 1'b0, '0, '0);
        rsp = seen;
        if (select == 3'd0 || int'(select) > NUM_LINKS) begin
            assert (cycles == 1)
                else report_error($sformatf("Bad select answered after %0d cycles", cycles));
        end else begin
            // The first edge is where the request is seen.
            assert (cycles - 1 >= MIN_LATENCY)
                else report_error($sformatf("Link reply after only %0d cycles", cycles - 1));
        end
    endtask

    task automatic check_reply(input string what, input logic [2:0] got, input logic [2:0] exp);
        assert (got == exp)
            else report_error($sformatf("%s replied %b, expected %b", what, got, exp));
    endtask

    task automatic check_data(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got == exp)
            else report_error($sformatf("%s read %h, expected %h", what, got, exp));
    endtask

    task automatic check_idle_lines(input int cycles);
        for (int c = 0; c < cycles; c++) begin
            @(posedge wb_clk);
            #1;
            assert (link_tx == LINK_INV)
                else report_error($sformatf("Unexpected line activity %b", link_tx));
        end
    endtask

    // A master sees a reply only inside its own cycle, and one kind at a time.
    always @(negedge wb_clk) begin
        if (rst_n) begin
            assert (!((gtp_ack || gtp_err || gtp_rty) && !gtp_cyc))
                else report_error("gtp reply outside a gtp cycle");
            assert (!((dbg_ack || dbg_err || dbg_rty) && !dbg_cyc))
                else report_error("dbg reply outside a dbg cycle");
            assert ($onehot0({gtp_ack, gtp_err, gtp_rty}))
                else report_error("gtp got more than one reply kind");
            assert ($onehot0({dbg_ack, dbg_err, dbg_rty}))
                else report_error("dbg got more than one reply kind");
        end
    end

    // ####################################################################
    // Test sequence.
    // ####################################################################

    initial begin
        rst_n = 1'b0;
        err_rst = 1'b0;
        board_en = '1;
        drive_master(0, 1'b0, 3'd0, 1'b0, '0, '0);
        drive_master(1, 1'b0, 3'd0, 1'b0, '0, '0);
        repeat (10) @(posedge wb_clk);
        #1;
        rst_n = 1'b1;
        assert (bridge_err == '0) else report_error("bridge_err set after reset");

        // Every link, the inverted ones too.
        for (int l = 1; l <= NUM_LINKS; l++) begin
            bus_access(0, 3'(l), 1'b1, reg_addr(l), reg_data(l), rdat_g, rsp_g);
            check_reply($sformatf("gtp write link %0d", l), rsp_g, RSP_ACK);
        end
        for (int l = 1; l <= NUM_LINKS; l++) begin
            bus_access(0, 3'(l), 1'b0, reg_addr(l), '0, rdat_g, rsp_g);
            check_reply($sformatf("gtp read link %0d", l), rsp_g, RSP_ACK);
            check_data($sformatf("gtp link %0d", l), rdat_g, reg_data(l));
        end

        // dbg waits behind a gtp access on the same link.
        fork
            begin
                bus_access(0, 3'd2, 1'b1, reg_addr(6), 32'h600D_CAFE, rdat_g, rsp_g);
                done_g = $time;
            end
            begin
                repeat (5) @(posedge wb_clk);
                bus_access(1, 3'd2, 1'b0, reg_addr(2), '0, rdat_d, rsp_d);
                done_d = $time;
            end
        join
        check_reply("gtp shared write", rsp_g, RSP_ACK);
        check_reply("dbg shared read", rsp_d, RSP_ACK);
        check_data("dbg shared read", rdat_d, reg_data(2));
        assert (done_d > done_g) else report_error("dbg finished before gtp");
        bus_access(0, 3'd2, 1'b0, reg_addr(6), '0, rdat_g, rsp_g);
        check_reply("gtp readback", rsp_g, RSP_ACK);
        check_data("gtp readback", rdat_g, 32'h600D_CAFE);

        fork
            bus_access(0, 3'd0, 1'b1, reg_addr(1), 32'hDEAD_0000, rdat_g, rsp_g);
            check_idle_lines(20);
        join
        check_reply("gtp select 0", rsp_g, RSP_ERR);

        // Bit 21 asks for retry, bit 20 for error.
        bus_access(0, 3'd3, 1'b0, 22'h200001, '0, rdat_g, rsp_g);
        check_reply("gtp retry address", rsp_g, RSP_RTY);
        bus_access(1, 3'd4, 1'b1, 22'h100002, 32'h1234_5678, rdat_d, rsp_d);
        check_reply("dbg error address", rsp_d, RSP_ERR);
        assert (bridge_err == '0) else report_error("bridge_err set by a remote reply");

        // Link 5 without an answering board.
        board_en[4] = 1'b0;
        bus_access(0, 3'd5, 1'b0, reg_addr(5), '0, rdat_g, rsp_g);
        check_reply("gtp silent link", rsp_g, RSP_ERR);
        for (int c = 0; c < 20; c++) begin
            assert (bridge_err == 7'b0010000)
                else report_error($sformatf("bridge_err %b after link timeout", bridge_err));
            @(posedge wb_clk);
            #1;
        end
        err_rst = 1'b1;
        @(posedge wb_clk);
        #1;
        err_rst = 1'b0;
        assert (bridge_err == '0) else report_error("bridge_err not cleared by err_rst");
        board_en[4] = 1'b1;
        bus_access(0, 3'd5, 1'b1, reg_addr(9), 32'h5A5A_0005, rdat_g, rsp_g);
        check_reply("gtp write after recovery", rsp_g, RSP_ACK);
        bus_access(0, 3'd5, 1'b0, reg_addr(9), '0, rdat_g, rsp_g);
        check_reply("gtp read after recovery", rsp_g, RSP_ACK);
        check_data("gtp after recovery", rdat_g, 32'h5A5A_0005);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== surf_bridge.f ====
logic/rackctl_pkg.sv
logic/rackctl_phy.sv
logic/rackctl_wb_bridge.sv
logic/surf_bridge.sv
verification/rackctl_board_model.sv
verification/tb_surf_bridge.sv

// ==== Bender.yml ====
package:
  name: surf_bridge

sources:
  - logic/rackctl_pkg.sv
  - logic/rackctl_phy.sv
  - logic/rackctl_wb_bridge.sv
  - logic/surf_bridge.sv
  - target: test
    files:
      - verification/rackctl_board_model.sv
      - verification/tb_surf_bridge.sv
